/* logic/exeLowPkg.sv */
/* widths, encodings and stage structs of the lower execute stage
   referenced by scoped names from the RTL and the testbench */
package exeLowPkg;

    //////////////////////////////////////////////////
    // widths and counts
    //////////////////////////////////////////////////
    localparam int WordLen      = 32;
    localparam int GprNumLen    = 5;
    localparam int OperandCount = 2;
    localparam int FwdSrcCount  = 4;  // reg, premem, mem, wb

    // bit positions inside the one-hot forward select
    localparam int FwdRegBit    = 0;
    localparam int FwdPreMemBit = 1;
    localparam int FwdMemBit    = 2;
    localparam int FwdWbBit     = 3;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        AluAdd, AluAddu, AluSub, AluSubu,
        AluAnd, AluOr, AluXor, AluNor,
        AluSlt, AluSltu,
        AluSll, AluSrl, AluSra,
        AluLui
    } aluOpE;

    typedef logic [FwdSrcCount-1:0] fwdSelT;  // one-hot, zero selects nothing

    typedef enum logic [2:0] {LoadNone, LoadLb, LoadLbu, LoadLh, LoadLhu, LoadLw} loadModeE;
    typedef enum logic [1:0] {StoreSb, StoreSh, StoreSw} storeModeE;

    // lane code for the memory stage, sign travels separately
    typedef enum logic [2:0] {
        LaneB0, LaneB1, LaneB2, LaneB3, LaneHLow, LaneHHigh, LaneWord
    } loadSelE;

    typedef enum logic [4:0] {
        ExcNone = 5'd0,
        ExcAdEL = 5'd4,
        ExcAdES = 5'd5,
        ExcOv   = 5'd12
    } excCodeE;

    //////////////////////////////////////////////////
    // stage structs
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [WordLen-1:0] imm;
        logic               isReg;
        fwdSelT             fwdSel;
    } operandT;

    typedef struct packed {
        logic [GprNumLen-1:0]                    writeNum;  // 0 means no writeback
        operandT [OperandCount-1:0]              opnd;
        logic [OperandCount-1:0][WordLen-1:0]    regData;   // rs/rt from decode
        aluOpE                                   aluOp;
        logic                                    ovCheck;
        logic                                    memReq;
        logic                                    memWr;
        loadModeE                                loadMode;
        storeModeE                               storeMode;
        logic                                    hasException;
        excCodeE                                 excCode;
    } exeInstrT;

    typedef struct packed {
        logic [WordLen-1:0] preMem;
        logic [WordLen-1:0] mem;
        logic [WordLen-1:0] wb;
    } fwdBusT;

    typedef struct packed {
        logic               memReq;
        logic               memWr;
        logic [3:0]         byteEn;
        logic [WordLen-1:0] storeData;
        loadSelE            loadLane;
        logic               loadSigned;
        logic [WordLen-1:0] addr;
    } memCtrlT;

    typedef struct packed {
        logic [GprNumLen-1:0] writeNum;
        logic [WordLen-1:0]   aluRes;
        memCtrlT              memCtrl;
        logic                 hasException;
        excCodeE              excCode;
    } exeResultT;

endpackage

/* logic/exeStageReg.sv */
/* holds one instruction between decode and premem
   valid/allowin handshake with flush, one cycle of latency */
module exeStageReg (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid_i,
    input  exeLowPkg::exeInstrT  instr_i,
    input  logic                 flush_i,
    input  logic                 downAllowIn_i,
    output logic                 hasData_o,
    output logic                 allowIn_o,
    output exeLowPkg::exeInstrT  instr_o
);
    logic                hasData;
    exeLowPkg::exeInstrT instrQ;

    // empty slot or premem takes the current one
    assign allowIn_o = !hasData || downAllowIn_i;

    always_ff @(posedge clk) begin
        if (!rst || flush_i) begin
            hasData <= 1'b0;
            instrQ  <= '0;
        end else if (allowIn_o) begin
            hasData <= inValid_i;
            // a bubble leaves a cleared slot behind
            if (inValid_i) begin
                instrQ <= instr_i;
            end else begin
                instrQ <= '0;
            end
        end
    end

    assign hasData_o = hasData;
    assign instr_o   = instrQ;

endmodule

/* logic/operandSelect.sv */
/* picks one ALU operand from the register value, a forward bus or the immediate
   one instance per operand */
module operandSelect (
    input  exeLowPkg::operandT             operand_i,
    input  logic [exeLowPkg::WordLen-1:0]  regData_i,
    input  exeLowPkg::fwdBusT              fwdBus_i,
    output logic [exeLowPkg::WordLen-1:0]  value_o
);
    exeLowPkg::fwdSelT             sel;
    logic [exeLowPkg::WordLen-1:0] fwdValue;

    assign sel = operand_i.fwdSel;

    // and-or mux, all-zero select gives zero
    assign fwdValue = ({exeLowPkg::WordLen{sel[exeLowPkg::FwdRegBit]}}    & regData_i)
                    | ({exeLowPkg::WordLen{sel[exeLowPkg::FwdPreMemBit]}} & fwdBus_i.preMem)
                    | ({exeLowPkg::WordLen{sel[exeLowPkg::FwdMemBit]}}    & fwdBus_i.mem)
                    | ({exeLowPkg::WordLen{sel[exeLowPkg::FwdWbBit]}}     & fwdBus_i.wb);

    assign value_o = operand_i.isReg ? fwdValue : operand_i.imm;  // imm covers sa too

endmodule

/* logic/execAlu.sv */
/* 32-bit integer ALU of the lower execute stage
   add/sub, logic, set-less-than, shifts and lui, with signed overflow */
module execAlu (
    input  exeLowPkg::aluOpE               aluOp_i,
    input  logic [exeLowPkg::WordLen-1:0]  src0_i,
    input  logic [exeLowPkg::WordLen-1:0]  src1_i,
    output logic [exeLowPkg::WordLen-1:0]  result_o,
    output logic                           overflow_o
);
    logic [exeLowPkg::WordLen-1:0] sum;
    logic [exeLowPkg::WordLen-1:0] diff;
    logic [4:0]                    shamt;
    logic                          addOv;
    logic                          subOv;
    logic                          signedLt;
    logic                          unsignedLt;

    assign sum   = src0_i + src1_i;
    assign diff  = src0_i - src1_i;
    assign shamt = src0_i[4:0];  // shift amount rides on operand 0

    // same-sign inputs with a flipped result sign
    assign addOv = (src0_i[exeLowPkg::WordLen-1] == src1_i[exeLowPkg::WordLen-1])
                && (sum[exeLowPkg::WordLen-1] != src0_i[exeLowPkg::WordLen-1]);
    assign subOv = (src0_i[exeLowPkg::WordLen-1] != src1_i[exeLowPkg::WordLen-1])
                && (diff[exeLowPkg::WordLen-1] != src0_i[exeLowPkg::WordLen-1]);

    assign signedLt   = $signed(src0_i) < $signed(src1_i);
    assign unsignedLt = src0_i < src1_i;

    //////////////////////////////////////////////////
    // result mux
    //////////////////////////////////////////////////
    always_comb begin
        result_o = '0;
        case (aluOp_i)
            exeLowPkg::AluAdd, exeLowPkg::AluAddu: result_o = sum;
            exeLowPkg::AluSub, exeLowPkg::AluSubu: result_o = diff;
            exeLowPkg::AluAnd:  result_o = src0_i & src1_i;
            exeLowPkg::AluOr:   result_o = src0_i | src1_i;
            exeLowPkg::AluXor:  result_o = src0_i ^ src1_i;
            exeLowPkg::AluNor:  result_o = ~(src0_i | src1_i);
            exeLowPkg::AluSlt:  result_o[0] = signedLt;
            exeLowPkg::AluSltu: result_o[0] = unsignedLt;
            exeLowPkg::AluSll:  result_o = src1_i << shamt;
            exeLowPkg::AluSrl:  result_o = src1_i >> shamt;
            exeLowPkg::AluSra:  result_o = $signed(src1_i) >>> shamt;
            exeLowPkg::AluLui:  result_o = src1_i << 16;
            default:            result_o = '0;
        endcase
    end

    // unsigned variants never trap
    assign overflow_o = ((aluOp_i == exeLowPkg::AluAdd) && addOv)
                     || ((aluOp_i == exeLowPkg::AluSub) && subOv);

endmodule

/* logic/memAccessPrep.sv */
/* load/store preparation and exception select for the lower execute stage
   forms the byte enables, store data, load lane and the outgoing result */
module memAccessPrep (
    input  exeLowPkg::exeInstrT            instr_i,
    input  logic [exeLowPkg::WordLen-1:0]  aluRes_i,
    input  logic [exeLowPkg::WordLen-1:0]  storeSrc_i,
    input  logic                           overflow_i,
    output exeLowPkg::exeResultT           result_o
);
    logic [1:0]                    align;
    logic                          isLoad;
    logic                          isStore;
    logic                          isHalfLoad;
    logic                          loadMisalign;
    logic                          storeMisalign;
    logic [3:0]                    byteEn;
    logic [exeLowPkg::WordLen-1:0] storeData;
    exeLowPkg::loadSelE            loadLane;

    assign align   = aluRes_i[1:0];  // address comes straight from the ALU
    assign isLoad  = instr_i.memReq && !instr_i.memWr;
    assign isStore = instr_i.memReq && instr_i.memWr;

    //////////////////////////////////////////////////
    // store side
    //////////////////////////////////////////////////
    always_comb begin
        byteEn    = 4'b0000;
        storeData = '0;
        if (isStore) begin
            case (instr_i.storeMode)
                exeLowPkg::StoreSb: begin
                    byteEn    = 4'b0001 << align;
                    storeData = {4{storeSrc_i[7:0]}};
                end
                exeLowPkg::StoreSh: begin
                    byteEn    = align[1] ? 4'b1100 : 4'b0011;
                    storeData = {2{storeSrc_i[15:0]}};
                end
                default: begin  // sw
                    byteEn    = 4'b1111;
                    storeData = storeSrc_i;
                end
            endcase
        end else if (isLoad) begin
            byteEn = 4'b1111;  // loads read the whole word
        end
    end

    //////////////////////////////////////////////////
    // load side
    //////////////////////////////////////////////////
    assign isHalfLoad = (instr_i.loadMode == exeLowPkg::LoadLh)
                     || (instr_i.loadMode == exeLowPkg::LoadLhu);

    always_comb begin
        loadLane = exeLowPkg::LaneWord;
        if (isLoad) begin
            case (instr_i.loadMode)
                exeLowPkg::LoadLb, exeLowPkg::LoadLbu:
                    loadLane = exeLowPkg::loadSelE'({1'b0, align});
                exeLowPkg::LoadLh, exeLowPkg::LoadLhu:
                    loadLane = align[1] ? exeLowPkg::LaneHHigh : exeLowPkg::LaneHLow;
                default:
                    loadLane = exeLowPkg::LaneWord;
            endcase
        end
    end

    // misaligned halfword or word, only with a real request
    assign loadMisalign = isLoad
        && ((isHalfLoad && align[0])
        || ((instr_i.loadMode == exeLowPkg::LoadLw) && (align != 2'b00)));
    assign storeMisalign = isStore
        && (((instr_i.storeMode == exeLowPkg::StoreSh) && align[0])
        || ((instr_i.storeMode == exeLowPkg::StoreSw) && (align != 2'b00)));

    //////////////////////////////////////////////////
    // result with exception priority
    //////////////////////////////////////////////////
    always_comb begin
        result_o                     = '0;
        result_o.writeNum            = instr_i.writeNum;
        result_o.aluRes              = aluRes_i;
        result_o.memCtrl.memReq      = instr_i.memReq;
        result_o.memCtrl.memWr       = instr_i.memWr;
        result_o.memCtrl.byteEn      = byteEn;
        result_o.memCtrl.storeData   = storeData;
        result_o.memCtrl.loadLane    = loadLane;
        result_o.memCtrl.loadSigned  = isLoad && ((instr_i.loadMode == exeLowPkg::LoadLb)
                                    || (instr_i.loadMode == exeLowPkg::LoadLh));
        result_o.memCtrl.addr        = aluRes_i;
        result_o.hasException        = 1'b1;
        if (instr_i.hasException) begin
            result_o.excCode = instr_i.excCode;  // earlier stage wins
        end else if (instr_i.ovCheck && overflow_i) begin
            result_o.excCode = exeLowPkg::ExcOv;
        end else if (loadMisalign) begin
            result_o.excCode = exeLowPkg::ExcAdEL;
        end else if (storeMisalign) begin
            result_o.excCode = exeLowPkg::ExcAdES;
        end else begin
            result_o.hasException = 1'b0;
            result_o.excCode      = exeLowPkg::ExcNone;
        end
    end

endmodule

/* logic/exeLowStage.sv */
/* lower execute stage between decode and premem
   stage register, forwarding muxes, ALU and load/store preparation */
module exeLowStage (
    input  logic                  clk,
    input  logic                  rst,
    // decode side
    input  logic                  inValid_i,
    input  exeLowPkg::exeInstrT   instr_i,
    output logic                  allowIn_o,
    // forwarding and flush
    input  exeLowPkg::fwdBusT     fwdBus_i,
    input  logic                  flush_i,
    // premem side
    output logic                  outValid_o,
    output exeLowPkg::exeResultT  result_o,
    input  logic                  downAllowIn_i
);
    exeLowPkg::exeInstrT                                           heldInstr;
    logic [exeLowPkg::OperandCount-1:0][exeLowPkg::WordLen-1:0]    opValue;
    logic [exeLowPkg::WordLen-1:0]                                 aluRes;
    logic                                                          aluOverflow;

    exeStageReg stageRegU (
        .clk           (clk),
        .rst           (rst),
        .inValid_i     (inValid_i),
        .instr_i       (instr_i),
        .flush_i       (flush_i),
        .downAllowIn_i (downAllowIn_i),
        .hasData_o     (outValid_o),   // valid whenever the slot is full
        .allowIn_o     (allowIn_o),
        .instr_o       (heldInstr)
    );

    //////////////////////////////////////////////////
    // operand forwarding
    //////////////////////////////////////////////////
    for (genvar i = 0; i < exeLowPkg::OperandCount; i++) begin : genOpSel
        operandSelect operandSelectU (
            .operand_i (heldInstr.opnd[i]),
            .regData_i (heldInstr.regData[i]),
            .fwdBus_i  (fwdBus_i),
            .value_o   (opValue[i])
        );
    end

    execAlu execAluU (
        .aluOp_i    (heldInstr.aluOp),
        .src0_i     (opValue[0]),
        .src1_i     (opValue[1]),
        .result_o   (aluRes),
        .overflow_o (aluOverflow)
    );

    // store data is operand 1 after forwarding
    memAccessPrep memAccessPrepU (
        .instr_i    (heldInstr),
        .aluRes_i   (aluRes),
        .storeSrc_i (opValue[1]),
        .overflow_i (aluOverflow),
        .result_o   (result_o)
    );

endmodule

/* dv/exeLowStage_assertions.sv */
/* handshake and forward-select properties of the stage register
   bound into exeStageReg */
module exeLowStage_assertions (
    input logic                clk,
    input logic                rst,
    input logic                flush_i,
    input logic                hasData_o,
    input logic                allowIn_o,
    input exeLowPkg::exeInstrT instr_o
);
    int failCount = 0;

    // a stalled instruction stays in place until premem takes it
    stallHolds: assert property (@(posedge clk) disable iff (!rst)
        hasData_o && !allowIn_o && !flush_i |=> hasData_o && $stable(instr_o))
        else begin $error("held instruction changed under back-pressure"); failCount++; end

    flushEmpties: assert property (@(posedge clk) disable iff (!rst) flush_i |=> !hasData_o)
        else begin $error("stage still holds data after a flush"); failCount++; end

    // forward select one-hot or zero on register operands
    selOneHot: assert property (@(posedge clk) disable iff (!rst)
        (!instr_o.opnd[0].isReg || $onehot0(instr_o.opnd[0].fwdSel))
        && (!instr_o.opnd[1].isReg || $onehot0(instr_o.opnd[1].fwdSel)))
        else begin $error("forward select is not one-hot"); failCount++; end

endmodule

bind exeStageReg exeLowStage_assertions stageRegChecks (.*);

/* dv/exeLowStage_tb.sv */
/* random-stimulus testbench for the lower execute stage
   a handshake model and a reference result are checked every cycle */
module exeLowStage_tb;
    localparam int NumCycles = 4000;

    logic                 clk = 1'b0;
    logic                 rst, inValid, flush, downAllowIn, allowIn, outValid;
    exeLowPkg::exeInstrT  instr, mInstr;
    exeLowPkg::fwdBusT    fwdBus;
    exeLowPkg::exeResultT result;
    logic                 mHas;
    integer               seed = 32'h81b9_77d4;
    int                   errors = 0;

    exeLowStage UUT (
        .clk(clk), .rst(rst), .inValid_i(inValid), .instr_i(instr), .allowIn_o(allowIn),
        .fwdBus_i(fwdBus), .flush_i(flush), .outValid_o(outValid), .result_o(result),
        .downAllowIn_i(downAllowIn)
    );

    always #20 clk = ~clk;

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    function automatic exeLowPkg::operandT randOperand();
        exeLowPkg::operandT op;
        logic [31:0]        r;
        r         = $random(seed);
        op.imm    = $random(seed);
        op.isReg  = r[6:5] != 2'b00;
        op.fwdSel = 4'b0001 << r[2:1];
        if (r[4:3] == 2'b00) op.fwdSel = '0;  // now and then no source at all
        return op;
    endfunction

    function automatic exeLowPkg::exeInstrT randInstr();
        exeLowPkg::exeInstrT ins;
        logic [31:0]         r;
        ins           = '0;
        r             = $random(seed);
        ins.writeNum  = r[4:0];
        ins.aluOp     = exeLowPkg::aluOpE'(4'(r[12:5] % 14));
        ins.ovCheck   = r[13];
        ins.memReq    = r[15:14] == 2'b00;
        ins.memWr     = r[16];
        ins.loadMode  = exeLowPkg::loadModeE'(3'(r[20:17] % 5 + 1));
        ins.storeMode = exeLowPkg::storeModeE'(2'(r[24:21] % 3));
        ins.hasException = r[28:25] == 4'h0;
        if (ins.hasException) ins.excCode = r[29] ? exeLowPkg::ExcAdEL : exeLowPkg::ExcOv;
        for (int i = 0; i < exeLowPkg::OperandCount; i++) begin
            ins.opnd[i]    = randOperand();
            ins.regData[i] = $random(seed);
        end
        return ins;
    endfunction

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] opValue(input exeLowPkg::operandT op, input logic [31:0] rd,
                                            input exeLowPkg::fwdBusT fb);
        if (!op.isReg) return op.imm;
        case (op.fwdSel)
            4'b0001: return rd;
            4'b0010: return fb.preMem;
            4'b0100: return fb.mem;
            4'b1000: return fb.wb;
            default: return '0;
        endcase
    endfunction

    function automatic exeLowPkg::exeResultT expResult(input exeLowPkg::exeInstrT ins,
                                                       input exeLowPkg::fwdBusT fb);
        exeLowPkg::exeResultT res;
        logic [31:0]          a, b;
        logic [32:0]          wide;
        logic                 ov, ld, st, mis;
        logic [1:0]           lo;
        res = '0;
        ov  = 1'b0;
        a   = opValue(ins.opnd[0], ins.regData[0], fb);
        b   = opValue(ins.opnd[1], ins.regData[1], fb);
        case (ins.aluOp)
            exeLowPkg::AluAdd, exeLowPkg::AluAddu: begin
                wide = {a[31], a} + {b[31], b};  // sign-extended so bit 32 against 31 flags overflow
                res.aluRes = wide[31:0];
                ov = (ins.aluOp == exeLowPkg::AluAdd) && (wide[32] != wide[31]);
            end
            exeLowPkg::AluSub, exeLowPkg::AluSubu: begin
                wide = {a[31], a} - {b[31], b};
                res.aluRes = wide[31:0];
                ov = (ins.aluOp == exeLowPkg::AluSub) && (wide[32] != wide[31]);
            end
            exeLowPkg::AluAnd:  res.aluRes = a & b;
            exeLowPkg::AluOr:   res.aluRes = a | b;
            exeLowPkg::AluXor:  res.aluRes = a ^ b;
            exeLowPkg::AluNor:  res.aluRes = ~(a | b);
            exeLowPkg::AluSlt:  res.aluRes = {31'b0, $signed(a) < $signed(b)};
            exeLowPkg::AluSltu: res.aluRes = {31'b0, a < b};
            exeLowPkg::AluSll:  res.aluRes = b << a[4:0];
            exeLowPkg::AluSrl:  res.aluRes = b >> a[4:0];
            exeLowPkg::AluSra:  res.aluRes = $unsigned($signed(b) >>> a[4:0]);
            exeLowPkg::AluLui:  res.aluRes = {b[15:0], 16'h0000};
            default:            res.aluRes = '0;
        endcase
        lo  = res.aluRes[1:0];
        ld  = ins.memReq && !ins.memWr;
        st  = ins.memReq && ins.memWr;
        mis = 1'b0;
        res.writeNum          = ins.writeNum;
        res.memCtrl.memReq    = ins.memReq;
        res.memCtrl.memWr     = ins.memWr;
        res.memCtrl.addr      = res.aluRes;
        res.memCtrl.loadLane  = exeLowPkg::LaneWord;
        if (st) begin
            case (ins.storeMode)
                exeLowPkg::StoreSb: begin
                    res.memCtrl.byteEn = 4'b0001 << lo;
                    res.memCtrl.storeData = {4{b[7:0]}};
                end
                exeLowPkg::StoreSh: begin
                    res.memCtrl.byteEn = lo[1] ? 4'b1100 : 4'b0011;
                    res.memCtrl.storeData = {2{b[15:0]}};
                    mis = lo[0];
                end
                default: begin
                    res.memCtrl.byteEn = 4'b1111;
                    res.memCtrl.storeData = b;
                    mis = lo != 2'b00;
                end
            endcase
        end else if (ld) begin
            res.memCtrl.byteEn = 4'b1111;
            res.memCtrl.loadSigned = (ins.loadMode == exeLowPkg::LoadLb)
                                  || (ins.loadMode == exeLowPkg::LoadLh);
            case (ins.loadMode)
                exeLowPkg::LoadLb, exeLowPkg::LoadLbu:
                    res.memCtrl.loadLane = exeLowPkg::loadSelE'({1'b0, lo});
                exeLowPkg::LoadLh, exeLowPkg::LoadLhu: begin
                    res.memCtrl.loadLane = lo[1] ? exeLowPkg::LaneHHigh : exeLowPkg::LaneHLow;
                    mis = lo[0];
                end
                default: mis = lo != 2'b00;
            endcase
        end
        // incoming first, then overflow, load address and store address
        res.hasException = 1'b1;
        if (ins.hasException) res.excCode = ins.excCode;
        else if (ins.ovCheck && ov) res.excCode = exeLowPkg::ExcOv;
        else if (ld && mis) res.excCode = exeLowPkg::ExcAdEL;
        else if (st && mis) res.excCode = exeLowPkg::ExcAdES;
        else res.hasException = 1'b0;
        return res;
    endfunction

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        rst = 1'b0;
        inValid = 1'b0;
        flush = 1'b0;
        downAllowIn = 1'b0;
        instr = '0;
        fwdBus = '0;
        mHas = 1'b0;
        mInstr = '0;
        repeat (4) @(posedge clk);
        #2 rst = 1'b1;
        for (int c = 0; c < NumCycles; c++) begin
            @(posedge clk);
            if (flush) begin
                mHas = 1'b0;
                mInstr = '0;
            end else if (!mHas || downAllowIn) begin
                mHas = inValid;
                if (inValid) mInstr = instr;
                else mInstr = '0;
            end
            #2;
            inValid     = ($random(seed) & 3) != 0;
            downAllowIn = ($random(seed) & 3) != 0;  // back-pressure about a quarter of the time
            flush       = ($random(seed) & 31) == 0;
            instr       = randInstr();
            fwdBus      = {$random(seed), $random(seed), $random(seed)};
            @(negedge clk);
            check("handshake", 128'({outValid, allowIn}), 128'({mHas, !mHas || downAllowIn}));
            if (mHas) check("result", 128'(result), 128'(expResult(mInstr, fwdBus)));
        end
        errors += UUT.stageRegU.stageRegChecks.failCount;
        $display("errors: %0d, assertion failures: %0d", errors,
                 UUT.stageRegU.stageRegChecks.failCount);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // run length plus reset and margin
    initial begin
        #((NumCycles + 20) * 40);
        $display("watchdog expired before the test sequence finished");
        $display("Verification failed");
        $finish;
    end

endmodule

/* exeLowStage.f */
logic/exeLowPkg.sv
logic/exeStageReg.sv
logic/operandSelect.sv
logic/execAlu.sv
logic/memAccessPrep.sv
logic/exeLowStage.sv
dv/exeLowStage_assertions.sv
dv/exeLowStage_tb.sv

/* Makefile */
# Verilator build and run of the lower execute stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module exeLowStage_tb -f exeLowStage.f -Mdir obj_dir

run: compile
	./obj_dir/VexeLowStage_tb +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; \
		then exit 1; fi

clean:
	rm -rf obj_dir sim.log
